// ==== include/elem_config.svh ====
`ifndef ELEM_CONFIG_SVH
`define ELEM_CONFIG_SVH

// vector shape
`define ELEM_LANES 32
`define ELEM_WIDTH 18

// Q-format fraction bits
`define ELEM_FRAC 8

// multiplier latency in enabled cycles and depth of the c delay
`define ELEM_MUL_DEPTH 3

`endif

// ==== verilog/elem_pkg.sv ====
`default_nettype none

`include "elem_config.svh"

package elem_pkg;

	typedef logic signed [`ELEM_WIDTH-1:0] lane_t;  // one fixed-point lane

	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,  // a*b
		OP_MAC  = 2'd1,  // c + a*b
		OP_NMAC = 2'd2,  // c - a*b
		OP_PASS = 2'd3   // c
	} elem_op_t;

endpackage

`default_nettype wire

// ==== verilog/delay_group.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module delay_group
	import elem_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  pipe_enable,
	input  lane_t c [`ELEM_LANES],
	output lane_t c_aligned [`ELEM_LANES]
);

	genvar l;

	generate
		for (l = 0; l < `ELEM_LANES; l = l + 1) begin : g_lane
			lane_t taps [`ELEM_MUL_DEPTH];

			always_ff @(posedge clk) begin
				if (reset) begin
					for (int s = 0; s < `ELEM_MUL_DEPTH; s = s + 1) begin
						taps[s] <= '0;
					end
				end else if (pipe_enable) begin
					taps[0] <= c[l];
					for (int s = 1; s < `ELEM_MUL_DEPTH; s = s + 1) begin
						taps[s] <= taps[s-1];
					end
				end
			end

			assign c_aligned[l] = taps[`ELEM_MUL_DEPTH-1];  // lines up with product
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/mul_array.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module mul_array
	import elem_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  pipe_enable,
	input  lane_t a [`ELEM_LANES],
	input  lane_t b [`ELEM_LANES],
	output lane_t product [`ELEM_LANES]
);

	localparam int PW = 2 * `ELEM_WIDTH;  // full product width

	// lane limits sign extended to the product width
	localparam logic signed [PW-1:0] SAT_HI = {{(PW-`ELEM_WIDTH+1){1'b0}},
		{(`ELEM_WIDTH-1){1'b1}}};
	localparam logic signed [PW-1:0] SAT_LO = {{(PW-`ELEM_WIDTH+1){1'b1}},
		{(`ELEM_WIDTH-1){1'b0}}};
	localparam logic signed [PW-1:0] HALF_LSB = PW'(1) << (`ELEM_FRAC - 1);

	genvar l;

	generate
		for (l = 0; l < `ELEM_LANES; l = l + 1) begin : g_lane
			lane_t a_q;
			lane_t b_q;
			logic signed [PW-1:0] prod_q;
			logic signed [PW-1:0] rounded;
			logic signed [PW-1:0] shifted;
			lane_t sat;
			lane_t product_q;

			// stage 1 registers the operands
			always_ff @(posedge clk) begin
				if (reset) begin
					a_q <= '0;
					b_q <= '0;
				end else if (pipe_enable) begin
					a_q <= a[l];
					b_q <= b[l];
				end
			end

			// stage 2 holds the full signed product
			always_ff @(posedge clk) begin
				if (reset) begin
					prod_q <= '0;
				end else if (pipe_enable) begin
					prod_q <= a_q * b_q;
				end
			end

			always_comb begin
				rounded = prod_q + HALF_LSB;  // round half up
				shifted = rounded >>> `ELEM_FRAC;
				if (shifted > SAT_HI) begin
					sat = SAT_HI[`ELEM_WIDTH-1:0];
				end else if (shifted < SAT_LO) begin
					sat = SAT_LO[`ELEM_WIDTH-1:0];
				end else begin
					sat = shifted[`ELEM_WIDTH-1:0];
				end
			end

			// stage 3 holds the rounded and saturated lane
			always_ff @(posedge clk) begin
				if (reset) begin
					product_q <= '0;
				end else if (pipe_enable) begin
					product_q <= sat;
				end
			end

			assign product[l] = product_q;
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/combine_array.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module combine_array
	import elem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     pipe_enable,
	input  elem_op_t stage_op,
	input  lane_t    product [`ELEM_LANES],
	input  lane_t    c_aligned [`ELEM_LANES],
	output lane_t    result [`ELEM_LANES]
);

	// top two bits differ only when the sum left the lane range
	function automatic lane_t clip(input logic signed [`ELEM_WIDTH:0] v);
		if (v[`ELEM_WIDTH] != v[`ELEM_WIDTH-1]) begin
			clip = v[`ELEM_WIDTH] ? {1'b1, {(`ELEM_WIDTH-1){1'b0}}} :
				{1'b0, {(`ELEM_WIDTH-1){1'b1}}};
		end else begin
			clip = v[`ELEM_WIDTH-1:0];
		end
	endfunction

	genvar l;

	generate
		for (l = 0; l < `ELEM_LANES; l = l + 1) begin : g_lane
			logic signed [`ELEM_WIDTH:0] sum;
			logic signed [`ELEM_WIDTH:0] diff;
			lane_t sel;
			lane_t result_q;

			always_comb begin
				sum  = c_aligned[l] + product[l];  // one guard bit
				diff = c_aligned[l] - product[l];
				case (stage_op)
					OP_MUL:  sel = product[l];
					OP_MAC:  sel = clip(sum);
					OP_NMAC: sel = clip(diff);
					default: sel = c_aligned[l];  // OP_PASS
				endcase
			end

			always_ff @(posedge clk) begin
				if (reset) begin
					result_q <= '0;
				end else if (pipe_enable) begin
					result_q <= sel;
				end
			end

			assign result[l] = result_q;
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/elem_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module elem_ctrl
	import elem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     hold,
	input  logic     in_valid,
	input  elem_op_t op,
	output logic     pipe_enable,
	output elem_op_t stage_op,
	output logic     out_valid
);

	logic issue;
	logic [`ELEM_MUL_DEPTH:0] valid_q;  // multiplier stages plus combine stage
	elem_op_t op_q [`ELEM_MUL_DEPTH];

	assign pipe_enable = ~hold;
	assign issue = in_valid & pipe_enable;  // no issue while frozen

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (pipe_enable) begin
			valid_q <= {valid_q[`ELEM_MUL_DEPTH-1:0], issue};
		end
	end

	// opcode follows its operands down the multiplier
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `ELEM_MUL_DEPTH; s = s + 1) begin
				op_q[s] <= OP_MUL;
			end
		end else if (pipe_enable) begin
			op_q[0] <= op;
			for (int s = 1; s < `ELEM_MUL_DEPTH; s = s + 1) begin
				op_q[s] <= op_q[s-1];
			end
		end
	end

	assign stage_op = op_q[`ELEM_MUL_DEPTH-1];  // meets product at combine input

	// a held result is reported once, when hold drops
	assign out_valid = valid_q[`ELEM_MUL_DEPTH] & pipe_enable;

endmodule

`default_nettype wire

// ==== verilog/elem_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module elem_top
	import elem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  logic     hold,
	input  elem_op_t op,
	input  lane_t    a [`ELEM_LANES],
	input  lane_t    b [`ELEM_LANES],
	input  lane_t    c [`ELEM_LANES],
	output logic     out_valid,
	output lane_t    result [`ELEM_LANES]
);

	logic pipe_enable;
	elem_op_t stage_op;
	lane_t product [`ELEM_LANES];
	lane_t c_aligned [`ELEM_LANES];

	elem_ctrl u_elem_ctrl (
		.clk         (clk),
		.reset       (reset),
		.hold        (hold),
		.in_valid    (in_valid),
		.op          (op),
		.pipe_enable (pipe_enable),
		.stage_op    (stage_op),
		.out_valid   (out_valid)
	);

	mul_array u_mul_array (
		.clk         (clk),
		.reset       (reset),
		.pipe_enable (pipe_enable),
		.a           (a),
		.b           (b),
		.product     (product)
	);

	// c waits here while a*b goes through the multiplier
	delay_group u_delay_group (
		.clk         (clk),
		.reset       (reset),
		.pipe_enable (pipe_enable),
		.c           (c),
		.c_aligned   (c_aligned)
	);

	combine_array u_combine_array (
		.clk         (clk),
		.reset       (reset),
		.pipe_enable (pipe_enable),
		.stage_op    (stage_op),
		.product     (product),
		.c_aligned   (c_aligned),
		.result      (result)
	);

endmodule

`default_nettype wire

// ==== verif/tb_elem_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "elem_config.svh"

module tb_elem_top
	import elem_pkg::*;
();

	localparam int SEED = 95724;
	localparam int NUM_RANDOM = 400;
	localparam int NUM_ISSUES = NUM_RANDOM + 40;  // random plus directed issues
	localparam int TIMEOUT_NS = (NUM_ISSUES * 4 + 200) * 10;
	localparam int LATENCY = `ELEM_MUL_DEPTH + 1;
	localparam int VEC_W = `ELEM_LANES * `ELEM_WIDTH;
	localparam longint LANE_MAX = (longint'(1) <<< (`ELEM_WIDTH - 1)) - 1;
	localparam longint LANE_MIN = -(longint'(1) <<< (`ELEM_WIDTH - 1));

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic hold;
	elem_op_t op;
	lane_t a [`ELEM_LANES];
	lane_t b [`ELEM_LANES];
	lane_t c [`ELEM_LANES];
	logic out_valid;
	lane_t result [`ELEM_LANES];

	logic [VEC_W-1:0] exp_q [$];  // expected vectors in issue order
	int tag_q [$];  // enabled-edge index of each accepted issue
	int en_edges = 0;

	elem_top u_elem_top (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.hold      (hold),
		.op        (op),
		.a         (a),
		.b         (b),
		.c         (c),
		.out_valid (out_valid),
		.result    (result)
	);

	always #5 clk = ~clk;

	task automatic abort_test(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic lane_t saturate(input longint v);
		if (v > LANE_MAX) begin
			return lane_t'(LANE_MAX);
		end else if (v < LANE_MIN) begin
			return lane_t'(LANE_MIN);
		end
		return lane_t'(v);
	endfunction

	// integer reference that rounds half up, shifts, clamps and combines with c
	function automatic lane_t model_lane(input elem_op_t o, input lane_t av, input lane_t bv,
		input lane_t cv);
		longint prod;
		longint acc;
		prod = longint'(av) * longint'(bv);
		prod = (prod + (longint'(1) <<< (`ELEM_FRAC - 1))) >>> `ELEM_FRAC;
		prod = longint'(saturate(prod));
		case (o)
			OP_MUL:  acc = prod;
			OP_MAC:  acc = longint'(cv) + prod;
			OP_NMAC: acc = longint'(cv) - prod;
			default: acc = longint'(cv);
		endcase
		return saturate(acc);
	endfunction

	function automatic lane_t pick_lane(input bit extremes);
		lane_t v;
		v = lane_t'($urandom);
		if (extremes) begin
			case ($urandom_range(0, 7))
				0: v = lane_t'(LANE_MAX);
				1: v = lane_t'(LANE_MIN);
				2: v = '0;
				3: v = '1;
				default: ;
			endcase
		end
		return v;
	endfunction

	task automatic fill_random(input bit extremes);
		for (int l = 0; l < `ELEM_LANES; l++) begin
			a[l] = pick_lane(extremes);
			b[l] = pick_lane(extremes);
			c[l] = pick_lane(extremes);
		end
	endtask

	task automatic start_issue(input elem_op_t o);
		@(negedge clk);
		in_valid = 1'b1;
		hold = 1'b0;
		op = o;
	endtask

	task automatic load_mul_corners();
		fill_random(1'b0);
		a[0] = 18'sd1;
		b[0] = 18'sd128;  // exactly half an lsb
		a[1] = 18'sd1;
		b[1] = 18'sd127;
		a[2] = -18'sd1;
		b[2] = 18'sd128;
		a[3] = -18'sd1;
		b[3] = 18'sd129;
		a[4] = lane_t'(LANE_MAX);
		b[4] = lane_t'(LANE_MAX);
		a[5] = lane_t'(LANE_MAX);
		b[5] = lane_t'(LANE_MIN);
		a[6] = lane_t'(LANE_MIN);
		b[6] = lane_t'(LANE_MIN);
		a[7] = -18'sd300;
		b[7] = 18'sd500;
	endtask

	// c at both limits against products of both signs
	task automatic load_sum_corners();
		fill_random(1'b1);
		for (int l = 0; l < 16; l++) begin
			c[l] = (l % 2 == 0) ? lane_t'(LANE_MAX) : lane_t'(LANE_MIN);
			a[l] = (l % 4 < 2) ? 18'sd16384 : -18'sd16384;
			b[l] = 18'sd256;
		end
	endtask

	task automatic drain();
		int waited;
		@(negedge clk);
		in_valid = 1'b0;
		hold = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < 4 * LATENCY) begin
			@(negedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else
			abort_test("results still missing after the pipeline drained");
	endtask

	// inputs change on the falling edge and are stable here
	always @(posedge clk) begin : monitor
		logic [VEC_W-1:0] exp_vec;
		int latency;
		lane_t exp_lane;
		if (reset) begin
			exp_q.delete();  // in-flight items are dropped
			tag_q.delete();
		end else begin
			assert (!(out_valid && hold)) else
				abort_test("out_valid was high while hold was high");
			if (out_valid) begin
				assert (exp_q.size() != 0) else
					abort_test("out_valid was high with no result outstanding");
				exp_vec = exp_q.pop_front();
				latency = en_edges - tag_q.pop_front();
				assert (latency == LATENCY) else abort_test($sformatf(
					"Fail out_valid latency: expected %h, got %h", LATENCY, latency));
				for (int l = 0; l < `ELEM_LANES; l++) begin
					exp_lane = exp_vec[l*`ELEM_WIDTH +: `ELEM_WIDTH];
					assert (result[l] == exp_lane) else abort_test($sformatf(
						"Fail result[%0d]: expected %h, got %h", l, exp_lane, result[l]));
				end
			end
			if (in_valid && !hold) begin
				for (int l = 0; l < `ELEM_LANES; l++) begin
					exp_vec[l*`ELEM_WIDTH +: `ELEM_WIDTH] = model_lane(op, a[l], b[l], c[l]);
				end
				exp_q.push_back(exp_vec);
				tag_q.push_back(en_edges);
			end
			if (!hold) begin
				en_edges++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS * 1ns);
		abort_test("watchdog timeout, the test did not finish in time");
	end

	initial begin
		int issued;
		void'($urandom(SEED));
		reset = 1'b1;
		in_valid = 1'b0;
		hold = 1'b0;
		op = OP_MUL;
		for (int l = 0; l < `ELEM_LANES; l++) begin
			a[l] = '0;
			b[l] = '0;
			c[l] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (5) @(negedge clk);  // idle with nothing in flight

		start_issue(OP_MUL);
		load_mul_corners();
		start_issue(OP_MAC);
		load_sum_corners();
		start_issue(OP_NMAC);
		load_sum_corners();
		start_issue(OP_MAC);
		fill_random(1'b1);
		repeat (8) begin
			start_issue(OP_PASS);  // back to back so c must stay with its issue
			fill_random(1'b1);
		end
		repeat (8) begin
			start_issue(OP_MUL);
			fill_random(1'b1);
		end
		drain();

		issued = 0;
		while (issued < NUM_RANDOM) begin
			@(negedge clk);
			hold = ($urandom_range(0, 3) == 0);
			in_valid = ($urandom_range(0, 3) != 0);
			op = elem_op_t'($urandom_range(0, 3));
			fill_random(1'b1);
			if (in_valid && !hold) begin
				issued++;
			end
		end
		drain();

		repeat (3) begin
			start_issue(OP_MAC);
			fill_random(1'b1);
		end
		@(negedge clk);
		reset = 1'b1;  // drop what is in flight
		in_valid = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (6) @(negedge clk);
		repeat (4) begin
			start_issue(elem_op_t'($urandom_range(0, 3)));
			fill_random(1'b1);
		end
		drain();

		if (exp_q.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_test("results missing at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
verilog/elem_pkg.sv
verilog/delay_group.sv
verilog/mul_array.sv
verilog/combine_array.sv
verilog/elem_ctrl.sv
verilog/elem_top.sv
verif/tb_elem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the elem_top testbench with Verilator.

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

TOP=tb_elem_top
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module "$TOP" \
	-f flist.f --Mdir "$BUILD_DIR" -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "FAIL: testbench reported a failure"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
	echo "FAIL: simulation ended without a result"
	exit 1
fi

echo "PASS"
exit 0
